// ==== mcu_trace_consts.svh ====
////////////////////////////////////////////////////////////////////////////
// Buffer geometry and register map for the trace capture subsystem
// NUM_ENTRIES must be a power of two and PTR_W must be its log2
// Packets are fixed at four words with a two bit word select
////////////////////////////////////////////////////////////////////////////
`ifndef MCU_TRACE_CONSTS_SVH
`define MCU_TRACE_CONSTS_SVH

// Buffer geometry
`define MCU_TRACE_NUM_ENTRIES   16
`define MCU_TRACE_PTR_W         4
`define MCU_TRACE_PKT_DWORDS    4
// Depth in 32-bit words as reported by CONFIG
`define MCU_TRACE_DEPTH_DWORDS  (`MCU_TRACE_NUM_ENTRIES * `MCU_TRACE_PKT_DWORDS)

// Register bus address width
`define MCU_TRACE_ADDR_W        8

// Register byte addresses
`define MCU_TRACE_ADDR_STATUS   8'h00
`define MCU_TRACE_ADDR_CONFIG   8'h04
`define MCU_TRACE_ADDR_WR_PTR   8'h08
`define MCU_TRACE_ADDR_RD_PTR   8'h0C
`define MCU_TRACE_ADDR_DATA     8'h10

`endif

// ==== mcu_trace_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Trace record, stored packet and buffer status types
// Word 0 of a packet sits in the low 32 bits
////////////////////////////////////////////////////////////////////////////
`default_nettype none

package mcu_trace_pkg;

    // One retired instruction as presented by the core
    typedef struct packed {
        logic [31:0] insn;
        logic [31:0] address;
        logic [31:0] tval;
        logic        exception;
        logic [4:0]  ecause;
        logic        interrupt;
    } trace_retire_t;

    // Stored packet, highest word first
    // Word 3 carries the flags in its low 7 bits
    typedef struct packed {
        logic [24:0] reserved;
        logic        interrupt;
        logic [4:0]  ecause;
        logic        exception;
        logic [31:0] tval;      // Word 2
        logic [31:0] address;   // Word 1
        logic [31:0] insn;      // Word 0
    } trace_packet_t;

    // Buffer state seen by the register stage
    typedef struct packed {
        logic        valid_data;
        logic        wrapped;
        // Next write entry scaled to words
        logic [31:0] wr_ptr;
    } trace_status_t;

endpackage

`default_nettype wire

// ==== mcu_trace_reg_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Register bus types for the debugger port
// Full-word accesses only, no byte enables
////////////////////////////////////////////////////////////////////////////
`default_nettype none

`include "mcu_trace_consts.svh"

package mcu_trace_reg_pkg;

    // Register map, byte addresses
    typedef enum logic [`MCU_TRACE_ADDR_W-1:0] {
        ADDR_STATUS = `MCU_TRACE_ADDR_STATUS,
        ADDR_CONFIG = `MCU_TRACE_ADDR_CONFIG,
        ADDR_WR_PTR = `MCU_TRACE_ADDR_WR_PTR,
        ADDR_RD_PTR = `MCU_TRACE_ADDR_RD_PTR,
        ADDR_DATA   = `MCU_TRACE_ADDR_DATA
    } reg_addr_e;

    // Request payload
    // Held steady by the master while reg_req is high
    typedef struct packed {
        logic                         write;
        logic [`MCU_TRACE_ADDR_W-1:0] addr;
        logic [31:0]                  wdata;
    } reg_req_t;

    // Response payload, valid while reg_ack is high
    typedef struct packed {
        logic [31:0] rdata;
        logic        err;
    } reg_rsp_t;

    // Four-phase slave handshake
    typedef enum logic [1:0] {
        IDLE,
        ACK,
        WAIT_REQ_LOW
    } csr_state_e;

endpackage

`default_nettype wire

// ==== mcu_trace_capture.sv ====
////////////////////////////////////////////////////////////////////////////
// Capture stage, one packet per valid retire record, no back-pressure
// Records outside debug mode are dropped here and nowhere else
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mcu_trace_capture
    import mcu_trace_pkg::*;
(
    input  logic          clk,
    input  logic          rst_b,
    input  logic          debug_en,
    input  logic          trace_valid,
    input  trace_retire_t trace_rec,
    output logic          pkt_valid,
    output trace_packet_t pkt
);

    logic          accept;
    trace_packet_t pkt_next;

    // Qualify retire with debug mode
    assign accept = trace_valid & debug_en;

    // Pack record into the four word layout
    always_comb begin
        pkt_next           = '0;
        pkt_next.insn      = trace_rec.insn;
        pkt_next.address   = trace_rec.address;
        pkt_next.tval      = trace_rec.tval;
        // Flags word, reserved bits stay zero
        pkt_next.exception = trace_rec.exception;
        pkt_next.ecause    = trace_rec.ecause;
        pkt_next.interrupt = trace_rec.interrupt;
    end

    //////////////////////////////////////////////////////////////////////////
    // Stage register
    //////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            pkt_valid <= 1'b0;
        end else begin
            pkt_valid <= accept;
        end
    end

    // Payload loads only on an accepted record
    always_ff @(posedge clk) begin
        if (accept) begin
            pkt <= pkt_next;
        end
    end

endmodule

`default_nettype wire

// ==== mcu_trace_store.sv ====
////////////////////////////////////////////////////////////////////////////
// Circular packet buffer, always accepts, oldest entry overwritten on wrap
// Read port is combinational from the word pointer
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mcu_trace_consts.svh"

module mcu_trace_store
    import mcu_trace_pkg::*;
(
    input  logic          clk,
    input  logic          rst_b,
    input  logic          pkt_valid,
    input  trace_packet_t pkt,
    input  logic [31:0]   rd_ptr,
    output trace_status_t status,
    output logic [31:0]   rd_data
);

    // Packet storage
    trace_packet_t buffer [`MCU_TRACE_NUM_ENTRIES];

    // Write side state
    logic [`MCU_TRACE_PTR_W-1:0] wr_idx;
    logic                        valid_data;
    logic                        wrapped;

    // Read side decode
    logic [`MCU_TRACE_PTR_W-1:0] rd_entry;
    logic [1:0]                  rd_word;
    trace_packet_t               rd_pkt;

    //////////////////////////////////////////////////////////////////////////
    // Write pointer and flags
    //////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            wr_idx     <= '0;
            valid_data <= 1'b0;
            wrapped    <= 1'b0;
        end else if (pkt_valid) begin
            valid_data <= 1'b1;
            // Last entry written, next write lands on entry 0
            if (&wr_idx) begin
                wrapped <= 1'b1;
            end
            // Power of two depth, index rolls over by itself
            wr_idx <= wr_idx + 1'b1;
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Buffer array
    //////////////////////////////////////////////////////////////////////////

    // Entries read as zero after reset
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            for (int i = 0; i < `MCU_TRACE_NUM_ENTRIES; i++) begin
                buffer[i] <= '0;
            end
        end else if (pkt_valid) begin
            buffer[wr_idx] <= pkt;
        end
    end

    // Status straight from the flops
    always_comb begin
        status.valid_data = valid_data;
        status.wrapped    = wrapped;
        // Entry index scaled to words
        status.wr_ptr     = 32'(wr_idx) * 32'(`MCU_TRACE_PKT_DWORDS);
    end

    //////////////////////////////////////////////////////////////////////////
    // Read port
    //////////////////////////////////////////////////////////////////////////

    // Entry is pointer div 4 mod depth
    // Upper pointer bits fall away
    assign rd_entry = rd_ptr[`MCU_TRACE_PTR_W+1:2];

    // Word within the packet
    assign rd_word = rd_ptr[1:0];

    assign rd_pkt  = buffer[rd_entry];
    assign rd_data = rd_pkt[32*rd_word +: 32];

endmodule

`default_nettype wire

// ==== mcu_trace_csr.sv ====
////////////////////////////////////////////////////////////////////////////
// Four-phase req/ack register slave, one access in flight at a time
// Every access is refused with err while debug mode is off
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mcu_trace_consts.svh"

module mcu_trace_csr
    import mcu_trace_pkg::*;
    import mcu_trace_reg_pkg::*;
(
    input  logic          clk,
    input  logic          rst_b,
    input  logic          debug_en,
    // Debugger bus
    input  logic          reg_req,
    input  reg_req_t      reg_req_data,
    output logic          reg_ack,
    output reg_rsp_t      reg_rsp,
    // Buffer side
    input  trace_status_t status,
    input  logic [31:0]   rd_data,
    output logic [31:0]   rd_ptr
);

    csr_state_e  state;
    reg_addr_e   req_addr;

    // Decode results
    logic [31:0] rdata_sel;
    logic        addr_hit;
    logic        write_ok;
    logic        rd_ptr_we;
    reg_rsp_t    rsp_next;

    assign req_addr = reg_addr_e'(reg_req_data.addr);

    //////////////////////////////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////////////////////////////

    // Read mux over the register map
    always_comb begin
        rdata_sel = '0;
        addr_hit  = 1'b1;
        write_ok  = 1'b0;
        case (req_addr)
            ADDR_STATUS: begin
                rdata_sel = {30'd0, status.wrapped, status.valid_data};
            end
            ADDR_CONFIG: begin
                rdata_sel = 32'(`MCU_TRACE_DEPTH_DWORDS);
            end
            ADDR_WR_PTR: begin
                rdata_sel = status.wr_ptr;
            end
            ADDR_RD_PTR: begin
                rdata_sel = rd_ptr;
                // Only writable register
                write_ok  = 1'b1;
            end
            ADDR_DATA: begin
                rdata_sel = rd_data;
            end
            default: begin
                addr_hit = 1'b0;
            end
        endcase
    end

    // Response and write enable
    always_comb begin
        rsp_next  = '0;
        rd_ptr_we = 1'b0;
        if (!debug_en || !addr_hit || (reg_req_data.write && !write_ok)) begin
            // Refused access, rdata stays zero and nothing changes
            rsp_next.err = 1'b1;
        end else if (reg_req_data.write) begin
            rd_ptr_we = 1'b1;
        end else begin
            rsp_next.rdata = rdata_sel;
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Handshake FSM
    //////////////////////////////////////////////////////////////////////////

    // IDLE samples reg_req
    // ACK performs the access and raises reg_ack with the response
    // WAIT_REQ_LOW holds both until the master lets go
    always_ff @(posedge clk or negedge rst_b) begin
        if (!rst_b) begin
            state   <= IDLE;
            reg_ack <= 1'b0;
            reg_rsp <= '0;
            rd_ptr  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (reg_req) begin
                        state <= ACK;
                    end
                end
                ACK: begin
                    reg_ack <= 1'b1;
                    reg_rsp <= rsp_next;
                    if (rd_ptr_we) begin
                        rd_ptr <= reg_req_data.wdata;
                    end
                    state <= WAIT_REQ_LOW;
                end
                WAIT_REQ_LOW: begin
                    // Master may stall here indefinitely
                    if (!reg_req) begin
                        reg_ack <= 1'b0;
                        state   <= IDLE;
                    end
                end
                default: begin
                    reg_ack <= 1'b0;
                    state   <= IDLE;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== mcu_trace_top.sv ====
////////////////////////////////////////////////////////////////////////////
// Trace subsystem top, capture then store then register stage
// Two edges from a retire record to visible status
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module mcu_trace_top
    import mcu_trace_pkg::*;
    import mcu_trace_reg_pkg::*;
(
    input  logic          clk,
    input  logic          rst_b,
    input  logic          debug_en,
    // Core retire port
    input  logic          trace_valid,
    input  trace_retire_t trace_rec,
    // Debugger bus
    input  logic          reg_req,
    input  reg_req_t      reg_req_data,
    output logic          reg_ack,
    output reg_rsp_t      reg_rsp
);

    // Capture to store
    logic          pkt_valid;
    trace_packet_t pkt;

    // Store to and from register stage
    trace_status_t status;
    logic [31:0]   rd_ptr;
    logic [31:0]   rd_data;

    mcu_trace_capture u_capture (
        .clk         (clk),
        .rst_b       (rst_b),
        .debug_en    (debug_en),
        .trace_valid (trace_valid),
        .trace_rec   (trace_rec),
        .pkt_valid   (pkt_valid),
        .pkt         (pkt)
    );

    mcu_trace_store u_store (
        .clk       (clk),
        .rst_b     (rst_b),
        .pkt_valid (pkt_valid),
        .pkt       (pkt),
        .rd_ptr    (rd_ptr),
        .status    (status),
        .rd_data   (rd_data)
    );

    mcu_trace_csr u_csr (
        .clk          (clk),
        .rst_b        (rst_b),
        .debug_en     (debug_en),
        .reg_req      (reg_req),
        .reg_req_data (reg_req_data),
        .reg_ack      (reg_ack),
        .reg_rsp      (reg_rsp),
        .status       (status),
        .rd_data      (rd_data),
        .rd_ptr       (rd_ptr)
    );

endmodule

`default_nettype wire

// ==== mcu_trace_tb.sv ====
////////////////////////////////////////////////////////////////////////////
// Testbench for the trace subsystem that stops at the first failing check
// Register accesses wait on reg_ack and records are checked two edges later
////////////////////////////////////////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

`include "mcu_trace_consts.svh"

module mcu_trace_tb
    import mcu_trace_pkg::*;
    import mcu_trace_reg_pkg::*;
();

    // Roughly 5000 cycles of tests with a wide margin
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int NUM            = `MCU_TRACE_NUM_ENTRIES;

    logic          clk = 1'b0;
    logic          rst_b;
    logic          debug_en;
    logic          trace_valid;
    trace_retire_t trace_rec;
    logic          reg_req;
    reg_req_t      reg_req_data;
    logic          reg_ack;
    reg_rsp_t      reg_rsp;

    integer        seed        = 11;
    int            cycle_count = 0;
    int            error_count = 0;
    logic          ack_prev    = 1'b0;
    logic          req_prev    = 1'b0;
    // Cycles the master keeps reg_req high after reg_ack, rotates 0 to 2
    int            req_hold    = 0;

    // Reference model of the buffer, pointers and flags
    logic [31:0]   model_words [NUM][4];
    int            model_wr      = 0;
    logic          model_valid   = 1'b0;
    logic          model_wrapped = 1'b0;
    logic [31:0]   model_rd_ptr  = '0;
    trace_retire_t pending_q [$];

    mcu_trace_top dut0 (
        .clk          (clk),
        .rst_b        (rst_b),
        .debug_en     (debug_en),
        .trace_valid  (trace_valid),
        .trace_rec    (trace_rec),
        .reg_req      (reg_req),
        .reg_req_data (reg_req_data),
        .reg_ack      (reg_ack),
        .reg_rsp      (reg_rsp)
    );

    // 100 ns clock
    always #50 clk = ~clk;

    task automatic stop_run(input string why);
        error_count++;
        $display("=== FAIL ===");
        $display("%s", why);
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
        stop_run($sformatf("mismatch %s expected 0x%08h actual 0x%08h", name, exp, act));
    endtask

    //////////////////////////////////////////////////////////////////////////
    // Watchdogs
    //////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        cycle_count++;
        assert (cycle_count < TIMEOUT_CYCLES)
            else stop_run("timeout, the tests did not finish within the cycle limit");
    end

    // Four-phase ordering sampled away from the edges
    always @(negedge clk) begin
        if (rst_b) begin
            assert (!(reg_ack && !ack_prev && !req_prev))
                else stop_run("reg_ack rose without a pending request");
            assert (!(!reg_ack && ack_prev && req_prev))
                else stop_run("reg_ack fell while reg_req was still high");
        end
        ack_prev = reg_ack;
        req_prev = reg_req;
    end

    //////////////////////////////////////////////////////////////////////////
    // Register bus master
    //////////////////////////////////////////////////////////////////////////

    task automatic reg_access(input logic write, input logic [7:0] addr,
                              input logic [31:0] wdata,
                              output logic [31:0] rd, output logic er);
        assert (!reg_ack) else stop_run("reg_ack still high at the start of an access");
        @(posedge clk);
        #1;
        reg_req_data.write = write;
        reg_req_data.addr  = addr;
        reg_req_data.wdata = wdata;
        reg_req            = 1'b1;
        do begin
            @(posedge clk);
            #1;
        end while (!reg_ack);
        // Master stalls with reg_req still high while the slave holds its response
        repeat (req_hold) begin
            @(posedge clk);
            #1;
        end
        req_hold = (req_hold + 1) % 3;
        rd      = reg_rsp.rdata;
        er      = reg_rsp.err;
        reg_req = 1'b0;
        // Next request only after ack is back low
        do begin
            @(posedge clk);
            #1;
        end while (reg_ack);
    endtask

    task automatic check_access(input string name, input logic write, input logic [7:0] addr,
                                input logic [31:0] wdata, input logic [31:0] exp_rdata,
                                input logic exp_err);
        logic [31:0] rd;
        logic        er;
        reg_access(write, addr, wdata, rd, er);
        assert (er === exp_err) else report_mismatch({name, " err"}, 32'(exp_err), 32'(er));
        // A good write has no read data to compare
        if (!write || exp_err) begin
            assert (rd === exp_rdata) else report_mismatch({name, " rdata"}, exp_rdata, rd);
        end
    endtask

    task automatic read_expect(input string name, input logic [7:0] addr,
                               input logic [31:0] exp);
        check_access(name, 1'b0, addr, 32'd0, exp, 1'b0);
    endtask

    task automatic set_rd_ptr(input string name, input logic [31:0] value);
        check_access({name, " rd_ptr write"}, 1'b1, ADDR_RD_PTR, value, 32'd0, 1'b0);
        model_rd_ptr = value;
        read_expect({name, " rd_ptr readback"}, ADDR_RD_PTR, value);
    endtask

    //////////////////////////////////////////////////////////////////////////
    // Reference model and record source
    //////////////////////////////////////////////////////////////////////////

    task automatic model_capture(input trace_retire_t rec);
        model_words[model_wr][0] = rec.insn;
        model_words[model_wr][1] = rec.address;
        model_words[model_wr][2] = rec.tval;
        // Exception in bit 0 with ecause above it and interrupt in bit 6
        model_words[model_wr][3] = {25'd0, rec.interrupt, rec.ecause, rec.exception};
        model_valid = 1'b1;
        if (model_wr == NUM - 1) begin
            model_wrapped = 1'b1;
        end
        model_wr = (model_wr + 1) % NUM;
    endtask

    // Random records on consecutive cycles
    task automatic send_burst(input int count);
        trace_retire_t rec;
        logic [31:0]   flags;
        @(posedge clk);
        #1;
        for (int i = 0; i < count; i++) begin
            rec.insn      = $random(seed);
            rec.address   = $random(seed);
            rec.tval      = $random(seed);
            flags         = $random(seed);
            rec.exception = flags[0];
            rec.ecause    = flags[5:1];
            rec.interrupt = flags[6];
            trace_rec     = rec;
            trace_valid   = 1'b1;
            pending_q.push_back(rec);
            @(posedge clk);
            #1;
        end
        trace_valid = 1'b0;
        // Capture edge then store edge
        @(posedge clk);
        @(posedge clk);
        while (pending_q.size() > 0) begin
            rec = pending_q.pop_front();
            if (debug_en) begin
                model_capture(rec);
            end
        end
    endtask

    task automatic check_status(input string name);
        read_expect({name, " status"}, ADDR_STATUS, {30'd0, model_wrapped, model_valid});
        read_expect({name, " config"}, ADDR_CONFIG, 32'(NUM * 4));
        read_expect({name, " wr_ptr"}, ADDR_WR_PTR, 32'(model_wr * 4));
    endtask

    // Every word of every entry through RD_PTR and DATA
    task automatic check_buffer(input string name);
        string tag;
        for (int e = 0; e < NUM; e++) begin
            for (int k = 0; k < 4; k++) begin
                tag = $sformatf("%s entry %0d word %0d", name, e, k);
                set_rd_ptr(tag, 32'(e * 4 + k));
                read_expect({tag, " data"}, ADDR_DATA, model_words[e][k]);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////////

    initial begin
        rst_b        = 1'b0;
        debug_en     = 1'b0;
        trace_valid  = 1'b0;
        trace_rec    = '0;
        reg_req      = 1'b0;
        reg_req_data = '0;
        for (int e = 0; e < NUM; e++) begin
            for (int k = 0; k < 4; k++) begin
                model_words[e][k] = '0;
            end
        end
        repeat (16) @(posedge clk);
        #1;
        rst_b    = 1'b1;
        debug_en = 1'b1;

        // Reset values
        check_status("reset");
        for (int p = 0; p < NUM * 4; p += 21) begin
            set_rd_ptr("reset", 32'(p));
            read_expect("reset data", ADDR_DATA, 32'd0);
        end

        // Partial fill with one record at a time
        repeat (7) send_burst(1);
        check_status("partial");
        check_buffer("partial");

        // Wrap to depth plus 5 records
        repeat (NUM + 5 - 7) send_burst(1);
        check_status("wrap");
        check_buffer("wrap");

        // With debug mode off records are dropped and the bus refuses
        @(posedge clk);
        #1;
        debug_en = 1'b0;
        send_burst(3);
        check_access("off status", 1'b0, ADDR_STATUS, 32'd0, 32'd0, 1'b1);
        check_access("off config", 1'b0, ADDR_CONFIG, 32'd0, 32'd0, 1'b1);
        check_access("off wr_ptr", 1'b0, ADDR_WR_PTR, 32'd0, 32'd0, 1'b1);
        check_access("off rd_ptr", 1'b0, ADDR_RD_PTR, 32'd0, 32'd0, 1'b1);
        check_access("off data", 1'b0, ADDR_DATA, 32'd0, 32'd0, 1'b1);
        check_access("off rd_ptr write", 1'b1, ADDR_RD_PTR, 32'h5, 32'd0, 1'b1);
        @(posedge clk);
        #1;
        debug_en = 1'b1;
        check_status("resume");
        read_expect("resume rd_ptr", ADDR_RD_PTR, model_rd_ptr);
        check_buffer("resume");
        send_burst(2);
        check_status("resume capture");

        // Read-only registers and unknown addresses
        check_access("write status", 1'b1, ADDR_STATUS, 32'hFFFF_FFFF, 32'd0, 1'b1);
        check_access("write config", 1'b1, ADDR_CONFIG, 32'hFFFF_FFFF, 32'd0, 1'b1);
        check_access("write wr_ptr", 1'b1, ADDR_WR_PTR, 32'hFFFF_FFFF, 32'd0, 1'b1);
        check_access("write data", 1'b1, ADDR_DATA, 32'hFFFF_FFFF, 32'd0, 1'b1);
        check_access("read 0x14", 1'b0, 8'h14, 32'd0, 32'd0, 1'b1);
        check_access("read 0x02", 1'b0, 8'h02, 32'd0, 32'd0, 1'b1);
        check_access("write 0x20", 1'b1, 8'h20, 32'h1234_5678, 32'd0, 1'b1);
        check_status("after refused");
        read_expect("after refused rd_ptr", ADDR_RD_PTR, model_rd_ptr);
        read_expect("after refused data", ADDR_DATA,
                    model_words[int'((model_rd_ptr / 4) % NUM)][int'(model_rd_ptr % 4)]);

        // Back-to-back records
        send_burst(10);
        check_status("burst");
        check_buffer("burst");

        if (error_count == 0) begin
            $display("=== PASS ===");
            $finish;
        end else begin
            stop_run("one or more checks failed");
        end
    end

endmodule

`default_nettype wire

// ==== mcu_trace.f ====
+incdir+.
mcu_trace_pkg.sv
mcu_trace_reg_pkg.sv
mcu_trace_capture.sv
mcu_trace_store.sv
mcu_trace_csr.sv
mcu_trace_top.sv
mcu_trace_tb.sv
